// ==== soc_pkg.sv ====
// Widths, address map and register layout of the peripheral bus.
// Address bits 7..6 pick the slave and bits 5..2 pick the register.
// Only two of the four slave-select values are mapped.
package soc_pkg;

   // ****************************************
   // Bus widths
   // ****************************************
   localparam int ADDR_W    = 8;
   localparam int DATA_W    = 32;
   localparam int GPIO_W    = 32;
   localparam int EXT_IRQ_W = 3;
   localparam int TMR_W     = 64;
   localparam int SW_IRQ_W  = 2;

   // ****************************************
   // Address map
   // ****************************************
   localparam int SLAVE_SEL_HI = 7;
   localparam int SLAVE_SEL_LO = 6;
   localparam int SLAVE_SEL_W  = SLAVE_SEL_HI - SLAVE_SEL_LO + 1;

   localparam logic [SLAVE_SEL_W-1:0] SLV_GPIO  = 2'd0;
   localparam logic [SLAVE_SEL_W-1:0] SLV_TIMER = 2'd1;

   // Register offset field inside a slave
   localparam int REG_OFS_HI = 5;
   localparam int REG_OFS_LO = 2;
   localparam int REG_OFS_W  = REG_OFS_HI - REG_OFS_LO + 1;

   // GPIO registers
   localparam logic [REG_OFS_W-1:0] GPIO_DATA_IN  = 4'd0;
   localparam logic [REG_OFS_W-1:0] GPIO_DATA_OUT = 4'd1;
   localparam logic [REG_OFS_W-1:0] GPIO_OE       = 4'd2;
   localparam logic [REG_OFS_W-1:0] GPIO_IRQ_MASK = 4'd3;
   localparam logic [REG_OFS_W-1:0] GPIO_IRQ_STAT = 4'd4;

   // Timer registers
   localparam logic [REG_OFS_W-1:0] TMR_TIME_LO = 4'd0;
   localparam logic [REG_OFS_W-1:0] TMR_TIME_HI = 4'd1;
   localparam logic [REG_OFS_W-1:0] TMR_CMP_LO  = 4'd2;
   localparam logic [REG_OFS_W-1:0] TMR_CMP_HI  = 4'd3;
   localparam logic [REG_OFS_W-1:0] TMR_SWIRQ   = 4'd4;

   // Compare parked at the far end so the timer interrupt starts idle
   localparam logic [TMR_W-1:0] TMR_CMP_RESET = '1;

endpackage

// ==== wb_if.sv ====
// Classic single-transfer Wishbone signal set without sel, cti or bte.
// The master keeps cyc, stb and the fields stable until ack or err.
`timescale 1ns/100ps

interface wb_if;

   logic                       cyc;
   logic                       stb;
   logic                       we;
   logic [soc_pkg::ADDR_W-1:0] adr;
   logic [soc_pkg::DATA_W-1:0] wdat;
   logic                       ack;
   logic                       err;
   logic [soc_pkg::DATA_W-1:0] rdat;

   modport master (
      output cyc, stb, we, adr, wdat,
      input  ack, err, rdat
   );

   modport slave (
      input  cyc, stb, we, adr, wdat,
      output ack, err, rdat
   );

endinterface

// ==== wb_host_bridge.sv ====
// One outstanding request at a time and no back-pressure.
// A request seen while o_busy is high is dropped and never answered.
`timescale 1ns/100ps

module wb_host_bridge (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_req,
   input  logic                       i_we,
   input  logic [soc_pkg::ADDR_W-1:0] i_addr,
   input  logic [soc_pkg::DATA_W-1:0] i_wdata,
   output logic                       o_rsp_valid,
   output logic [soc_pkg::DATA_W-1:0] o_rdata,
   output logic                       o_err,
   output logic                       o_busy,
   wb_if.master                       bus
);

   logic accept;
   logic done;

   // Busy while the cycle is open and through the response cycle
   assign o_busy = bus.cyc | o_rsp_valid;
   assign accept = i_req & ~o_busy;
   assign done   = bus.cyc & (bus.ack | bus.err);

   // ****************************************
   // Bus cycle and response strobe
   // ****************************************
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         bus.cyc     <= 1'b0;
         bus.stb     <= 1'b0;
         o_rsp_valid <= 1'b0;
         o_err       <= 1'b0;
      end else begin
         o_rsp_valid <= done;
         o_err       <= done & bus.err;
         if (accept) begin
            bus.cyc <= 1'b1;
            bus.stb <= 1'b1;
         end else if (done) begin
            bus.cyc <= 1'b0;
            bus.stb <= 1'b0;
         end
      end
   end

   // Request fields and read data
   always_ff @(posedge clk) begin
      if (accept) begin
         bus.we   <= i_we;
         bus.adr  <= i_addr;
         bus.wdat <= i_wdata;
      end
      if (done) begin
         o_rdata <= bus.rdat;
      end
   end

endmodule

// ==== wb_decoder.sv ====
// Routes on address bits 7..6 with no wait states of its own.
// Unmapped selects end with a registered err one cycle after stb.
`timescale 1ns/100ps

module wb_decoder (
   input  logic  clk,
   input  logic  i_rst_n,
   wb_if.slave   host,
   wb_if.master  gpio_bus,
   wb_if.master  tmr_bus
);

   logic [soc_pkg::SLAVE_SEL_W-1:0] sel;
   logic                            hit_gpio;
   logic                            hit_tmr;
   logic                            unmapped_err;

   assign sel      = host.adr[soc_pkg::SLAVE_SEL_HI:soc_pkg::SLAVE_SEL_LO];
   assign hit_gpio = (sel == soc_pkg::SLV_GPIO);
   assign hit_tmr  = (sel == soc_pkg::SLV_TIMER);

   // Fields fan out to both slaves, stb only to the selected one
   assign gpio_bus.cyc  = host.cyc;
   assign gpio_bus.stb  = host.stb & hit_gpio;
   assign gpio_bus.we   = host.we;
   assign gpio_bus.adr  = host.adr;
   assign gpio_bus.wdat = host.wdat;

   assign tmr_bus.cyc   = host.cyc;
   assign tmr_bus.stb   = host.stb & hit_tmr;
   assign tmr_bus.we    = host.we;
   assign tmr_bus.adr   = host.adr;
   assign tmr_bus.wdat  = host.wdat;

   // One-cycle error for a select value with no slave behind it
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         unmapped_err <= 1'b0;
      end else begin
         unmapped_err <= host.cyc & host.stb & ~hit_gpio & ~hit_tmr & ~unmapped_err;
      end
   end

   // Response mux
   always_comb begin
      host.ack  = 1'b0;
      host.err  = unmapped_err;
      host.rdat = '0;
      if (hit_gpio) begin
         host.ack  = gpio_bus.ack;
         host.err  = gpio_bus.err;
         host.rdat = gpio_bus.rdat;
      end else if (hit_tmr) begin
         host.ack  = tmr_bus.ack;
         host.err  = tmr_bus.err;
         host.rdat = tmr_bus.rdat;
      end
   end

endmodule

// ==== gpio_regs.sv ====
// Inputs pass a 2-flop synchronizer before DATA_IN and change detection.
// Unused offsets read as zero and ignore writes. GPIO_W must not exceed DATA_W.
`timescale 1ns/100ps

module gpio_regs (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic [soc_pkg::GPIO_W-1:0] i_gpio,
   output logic [soc_pkg::GPIO_W-1:0] o_gpio,
   output logic [soc_pkg::GPIO_W-1:0] o_gpio_oe,
   output logic                       o_irq,
   wb_if.slave                        bus
);

   logic [soc_pkg::REG_OFS_W-1:0] ofs;
   logic                          wr;
   logic [soc_pkg::GPIO_W-1:0]    gpio_meta;
   logic [soc_pkg::GPIO_W-1:0]    gpio_sync;
   logic [soc_pkg::GPIO_W-1:0]    gpio_prev;
   logic [soc_pkg::GPIO_W-1:0]    irq_mask;
   logic [soc_pkg::GPIO_W-1:0]    irq_stat;
   logic [soc_pkg::GPIO_W-1:0]    stat_clr;

   assign ofs      = bus.adr[soc_pkg::REG_OFS_HI:soc_pkg::REG_OFS_LO];
   assign wr       = bus.cyc & bus.stb & bus.we & ~bus.ack;
   assign stat_clr = (wr && ofs == soc_pkg::GPIO_IRQ_STAT) ? bus.wdat[soc_pkg::GPIO_W-1:0] : '0;
   assign bus.err  = 1'b0;
   assign o_irq    = |irq_stat;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         bus.ack   <= 1'b0;
         gpio_meta <= '0;
         gpio_sync <= '0;
         gpio_prev <= '0;
         o_gpio    <= '0;
         o_gpio_oe <= '0;
         irq_mask  <= '0;
         irq_stat  <= '0;
      end else begin
         bus.ack   <= bus.cyc & bus.stb & ~bus.ack;
         gpio_meta <= i_gpio;
         gpio_sync <= gpio_meta;
         gpio_prev <= gpio_sync;
         // Set wins over a clear in the same cycle
         irq_stat  <= (irq_stat & ~stat_clr) | ((gpio_sync ^ gpio_prev) & irq_mask);
         if (wr) begin
            case (ofs)
               soc_pkg::GPIO_DATA_OUT: o_gpio    <= bus.wdat[soc_pkg::GPIO_W-1:0];
               soc_pkg::GPIO_OE:       o_gpio_oe <= bus.wdat[soc_pkg::GPIO_W-1:0];
               soc_pkg::GPIO_IRQ_MASK: irq_mask  <= bus.wdat[soc_pkg::GPIO_W-1:0];
               default: ;
            endcase
         end
      end
   end

   // Read mux, held stable by the master until ack
   always_comb begin
      bus.rdat = '0;
      case (ofs)
         soc_pkg::GPIO_DATA_IN:  bus.rdat[soc_pkg::GPIO_W-1:0] = gpio_sync;
         soc_pkg::GPIO_DATA_OUT: bus.rdat[soc_pkg::GPIO_W-1:0] = o_gpio;
         soc_pkg::GPIO_OE:       bus.rdat[soc_pkg::GPIO_W-1:0] = o_gpio_oe;
         soc_pkg::GPIO_IRQ_MASK: bus.rdat[soc_pkg::GPIO_W-1:0] = irq_mask;
         soc_pkg::GPIO_IRQ_STAT: bus.rdat[soc_pkg::GPIO_W-1:0] = irq_stat;
         default: ;
      endcase
   end

endmodule

// ==== sys_timer.sv ====
// 64-bit time counts every clk and is read-only. LO and HI reads are not atomic.
// Compare writes are not atomic either, so park HI first when moving it down.
`timescale 1ns/100ps

module sys_timer (
   input  logic clk,
   input  logic i_rst_n,
   output logic o_timer_irq,
   output logic o_sw_irq3,
   output logic o_sw_irq4,
   wb_if.slave  bus
);

   logic [soc_pkg::REG_OFS_W-1:0] ofs;
   logic                          wr;
   logic [soc_pkg::TMR_W-1:0]     mtime;
   logic [soc_pkg::TMR_W-1:0]     mtimecmp;
   logic [soc_pkg::SW_IRQ_W-1:0]  sw_irq;

   assign ofs       = bus.adr[soc_pkg::REG_OFS_HI:soc_pkg::REG_OFS_LO];
   assign wr        = bus.cyc & bus.stb & bus.we & ~bus.ack;
   assign bus.err   = 1'b0;
   assign o_sw_irq3 = sw_irq[0];
   assign o_sw_irq4 = sw_irq[1];

   // ****************************************
   // Time counter and timer interrupt
   // ****************************************
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mtime       <= '0;
         o_timer_irq <= 1'b0;
      end else begin
         mtime       <= mtime + 1'b1;
         o_timer_irq <= (mtime >= mtimecmp);
      end
   end

   // ****************************************
   // Register writes
   // ****************************************
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         bus.ack  <= 1'b0;
         mtimecmp <= soc_pkg::TMR_CMP_RESET;
         sw_irq   <= '0;
      end else begin
         bus.ack <= bus.cyc & bus.stb & ~bus.ack;
         if (wr) begin
            case (ofs)
               soc_pkg::TMR_CMP_LO: mtimecmp[soc_pkg::DATA_W-1:0] <= bus.wdat;
               soc_pkg::TMR_CMP_HI: mtimecmp[soc_pkg::TMR_W-1:soc_pkg::DATA_W] <= bus.wdat;
               soc_pkg::TMR_SWIRQ:  sw_irq <= bus.wdat[soc_pkg::SW_IRQ_W-1:0];
               default: ;
            endcase
         end
      end
   end

   // Read mux
   always_comb begin
      bus.rdat = '0;
      case (ofs)
         soc_pkg::TMR_TIME_LO: bus.rdat = mtime[soc_pkg::DATA_W-1:0];
         soc_pkg::TMR_TIME_HI: bus.rdat = mtime[soc_pkg::TMR_W-1:soc_pkg::DATA_W];
         soc_pkg::TMR_CMP_LO:  bus.rdat = mtimecmp[soc_pkg::DATA_W-1:0];
         soc_pkg::TMR_CMP_HI:  bus.rdat = mtimecmp[soc_pkg::TMR_W-1:soc_pkg::DATA_W];
         soc_pkg::TMR_SWIRQ:   bus.rdat[soc_pkg::SW_IRQ_W-1:0] = sw_irq;
         default: ;
      endcase
   end

endmodule

// ==== periph_top.sv ====
// Every host access answers exactly 2 cycles after the request edge.
// GPIO pads are split into out, oe and in. Tristate lives in the board wrapper.
`timescale 1ns/100ps

module periph_top (
   input  logic                          clk,
   input  logic                          i_rst_n,
   // Host port
   input  logic                          i_req,
   input  logic                          i_we,
   input  logic [soc_pkg::ADDR_W-1:0]    i_addr,
   input  logic [soc_pkg::DATA_W-1:0]    i_wdata,
   output logic                          o_rsp_valid,
   output logic [soc_pkg::DATA_W-1:0]    o_rdata,
   output logic                          o_err,
   output logic                          o_busy,
   // GPIO pins
   input  logic [soc_pkg::GPIO_W-1:0]    i_gpio,
   output logic [soc_pkg::GPIO_W-1:0]    o_gpio,
   output logic [soc_pkg::GPIO_W-1:0]    o_gpio_oe,
   // Interrupts
   output logic                          o_timer_irq,
   output logic [soc_pkg::EXT_IRQ_W-1:0] o_ext_irq
);

   logic gpio_irq;
   logic sw_irq3;
   logic sw_irq4;

   wb_if host_bus ();
   wb_if gpio_bus ();
   wb_if tmr_bus ();

   wb_host_bridge bridge_i (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_req       (i_req),
      .i_we        (i_we),
      .i_addr      (i_addr),
      .i_wdata     (i_wdata),
      .o_rsp_valid (o_rsp_valid),
      .o_rdata     (o_rdata),
      .o_err       (o_err),
      .o_busy      (o_busy),
      .bus         (host_bus.master)
   );

   wb_decoder decoder_i (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .host     (host_bus.slave),
      .gpio_bus (gpio_bus.master),
      .tmr_bus  (tmr_bus.master)
   );

   gpio_regs gpio_i (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_gpio    (i_gpio),
      .o_gpio    (o_gpio),
      .o_gpio_oe (o_gpio_oe),
      .o_irq     (gpio_irq),
      .bus       (gpio_bus.slave)
   );

   sys_timer timer_i (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .o_timer_irq (o_timer_irq),
      .o_sw_irq3   (sw_irq3),
      .o_sw_irq4   (sw_irq4),
      .bus         (tmr_bus.slave)
   );

   // External interrupt order as seen by the core
   assign o_ext_irq = {sw_irq4, sw_irq3, gpio_irq};

endmodule

// ==== tb_clk_gen.sv ====
// Free-running 10 ns clock with an active-low reset held for 5 cycles.
// Reset is released on a falling edge, away from the DUT's sampling edge.
`timescale 1ns/100ps

module tb_clk_gen (
   output logic o_clk,
   output logic o_rst_n
);

   localparam int HALF_PERIOD_NS = 5;
   localparam int RESET_CYCLES   = 5;

   initial begin
      o_clk = 1'b0;
      forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
   end

   initial begin
      o_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_rst_n = 1'b1;
   end

endmodule

// ==== tb_periph_top.sv ====
// Table-driven testbench for periph_top. Inputs change on the falling clock edge
// and outputs are sampled on the falling edge. Stops at the first error.
`timescale 1ns/100ps

module tb_periph_top;

   localparam int RSP_LATENCY   = 2;
   localparam int RSP_TIMEOUT   = 20;
   localparam int TIMER_TIMEOUT = 1000;
   localparam int RESET_TIMEOUT = 50;

   // Step kinds
   localparam logic [2:0] OP_WRITE      = 3'd0;
   localparam logic [2:0] OP_READ       = 3'd1;
   localparam logic [2:0] OP_SET_GPIO   = 3'd2;
   localparam logic [2:0] OP_IDLE       = 3'd3;
   localparam logic [2:0] OP_CHECK_EXT  = 3'd4;
   localparam logic [2:0] OP_WAIT_TIMER = 3'd5;
   localparam logic [2:0] OP_CHECK_OUT  = 3'd6;
   localparam logic [2:0] OP_CHECK_OE   = 3'd7;

   typedef struct packed {
      logic [2:0]                 op;
      logic [soc_pkg::ADDR_W-1:0] addr;
      logic [soc_pkg::DATA_W-1:0] wdata;
      logic [soc_pkg::DATA_W-1:0] exp_data;
      logic                       exp_err;
   } step_t;

   logic                          clk;
   logic                          rst_n;
   logic                          i_req;
   logic                          i_we;
   logic [soc_pkg::ADDR_W-1:0]    i_addr;
   logic [soc_pkg::DATA_W-1:0]    i_wdata;
   logic                          o_rsp_valid;
   logic [soc_pkg::DATA_W-1:0]    o_rdata;
   logic                          o_err;
   logic                          o_busy;
   logic [soc_pkg::GPIO_W-1:0]    i_gpio;
   logic [soc_pkg::GPIO_W-1:0]    o_gpio;
   logic [soc_pkg::GPIO_W-1:0]    o_gpio_oe;
   logic                          o_timer_irq;
   logic [soc_pkg::EXT_IRQ_W-1:0] o_ext_irq;

   step_t  steps_q[$];
   integer seed;

   tb_clk_gen clk_gen_i (
      .o_clk   (clk),
      .o_rst_n (rst_n)
   );

   periph_top dut_i (
      .clk         (clk),
      .i_rst_n     (rst_n),
      .i_req       (i_req),
      .i_we        (i_we),
      .i_addr      (i_addr),
      .i_wdata     (i_wdata),
      .o_rsp_valid (o_rsp_valid),
      .o_rdata     (o_rdata),
      .o_err       (o_err),
      .o_busy      (o_busy),
      .i_gpio      (i_gpio),
      .o_gpio      (o_gpio),
      .o_gpio_oe   (o_gpio_oe),
      .o_timer_irq (o_timer_irq),
      .o_ext_irq   (o_ext_irq)
   );

   // ****************************************
   // Helpers
   // ****************************************
   task automatic stop_on_failure();
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h",
                  $time, name, actual, expected);
         stop_on_failure();
      end
   endtask

   // Word address from slave select and register offset
   function automatic logic [soc_pkg::ADDR_W-1:0] reg_addr(input logic [1:0] sel,
                                                           input logic [3:0] ofs);
      return {sel, ofs, 2'b00};
   endfunction

   task automatic add_step(input logic [2:0] op, input logic [soc_pkg::ADDR_W-1:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp_data,
                           input logic exp_err);
      steps_q.push_back(step_t'{op, addr, wdata, exp_data, exp_err});
   endtask

   // One host access, called on a falling edge
   task automatic run_access(input step_t s);
      int   cycles;
      logic seen;
      cycles  = 0;
      seen    = 1'b0;
      i_req   = 1'b1;
      i_we    = (s.op == OP_WRITE);
      i_addr  = s.addr;
      i_wdata = s.wdata;
      while (!seen) begin
         @(negedge clk);
         if (cycles == 0) begin
            i_req = 1'b0;
            check_value("o_busy", 64'(o_busy), 64'd1);
         end
         cycles++;
         if (o_rsp_valid) begin
            seen = 1'b1;
         end else if (cycles > RSP_TIMEOUT) begin
            $display("Timeout: no response for the access to address 0x%0h", s.addr);
            stop_on_failure();
         end
      end
      // First sample falls half a cycle after the request edge
      check_value("o_rsp_valid latency", 64'(cycles - 1), 64'(RSP_LATENCY));
      check_value("o_err", 64'(o_err), 64'(s.exp_err));
      if (s.op == OP_READ) begin
         check_value("o_rdata", 64'(o_rdata), 64'(s.exp_data));
      end
      @(negedge clk);
      check_value("o_rsp_valid width", 64'(o_rsp_valid), 64'd0);
   endtask

   task automatic wait_timer_irq(input logic level);
      int cycles;
      cycles = 0;
      while (o_timer_irq !== level) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMER_TIMEOUT) begin
            $display("Timeout: o_timer_irq never reached %0b", level);
            stop_on_failure();
         end
      end
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (rst_n !== 1'b1) begin
         @(negedge clk);
         cycles++;
         if (cycles > RESET_TIMEOUT) begin
            $display("Timeout: reset was never released");
            stop_on_failure();
         end
      end
   endtask

   // ****************************************
   // Stimulus table
   // ****************************************
   task automatic build_steps(input logic [31:0] pat);
      // Reset values
      add_step(OP_READ, reg_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_DATA_OUT), 0, 0, 0);
      add_step(OP_READ, reg_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_OE), 0, 0, 0);
      add_step(OP_READ, reg_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_SWIRQ), 0, 0, 0);
      add_step(OP_READ, reg_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_CMP_LO), 0, 32'hffff_ffff, 0);
      add_step(OP_READ, reg_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_CMP_HI), 0, 32'hffff_ffff, 0);
      add_step(OP_CHECK_EXT, 0, 0, 0, 0);
      add_step(OP_WAIT_TIMER, 0, 0, 0, 0);
      // GPIO outputs
      add_step(OP_WRITE, reg_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_DATA_OUT),
               32'ha5c3_0f96, 0, 0);
      add_step(OP_READ, reg_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_DATA_OUT),
               0, 32'ha5c3_0f96, 0);
      add_step(OP_CHECK_OUT, 0, 0, 32'ha5c3_0f96, 0);
      add_step(OP_WRITE, reg_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_OE), 32'h00ff_f00f, 0, 0);
      add_step(OP_READ, reg_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_OE), 0, 32'h00ff_f00f, 0);
      add_step(OP_CHECK_OE, 0, 0, 32'h00ff_f00f, 0);
      // GPIO inputs, mask on bit 0 only
      add_step(OP_SET_GPIO, 0, pat, 0, 0);
      add_step(OP_IDLE, 0, 3, 0, 0);
      add_step(OP_READ, reg_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_DATA_IN), 0, pat, 0);
      add_step(OP_WRITE, reg_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_IRQ_MASK), 1, 0, 0);
      add_step(OP_SET_GPIO, 0, pat ^ 32'h2, 0, 0);
      add_step(OP_IDLE, 0, 4, 0, 0);
      add_step(OP_CHECK_EXT, 0, 0, 0, 0);
      add_step(OP_READ, reg_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_IRQ_STAT), 0, 0, 0);
      add_step(OP_SET_GPIO, 0, pat ^ 32'h3, 0, 0);
      add_step(OP_IDLE, 0, 4, 0, 0);
      add_step(OP_CHECK_EXT, 0, 0, 32'h1, 0);
      add_step(OP_READ, reg_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_IRQ_STAT), 0, 1, 0);
      add_step(OP_WRITE, reg_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_IRQ_STAT), 1, 0, 0);
      add_step(OP_CHECK_EXT, 0, 0, 0, 0);
      add_step(OP_READ, reg_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_IRQ_STAT), 0, 0, 0);
      // Timer compare, HI first in both directions
      add_step(OP_WRITE, reg_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_CMP_HI), 0, 0, 0);
      add_step(OP_WRITE, reg_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_CMP_LO), 32'h20, 0, 0);
      add_step(OP_WAIT_TIMER, 0, 0, 1, 0);
      add_step(OP_READ, reg_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_TIME_HI), 0, 0, 0);
      add_step(OP_WRITE, reg_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_CMP_HI),
               32'hffff_ffff, 0, 0);
      add_step(OP_WRITE, reg_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_CMP_LO),
               32'hffff_ffff, 0, 0);
      add_step(OP_WAIT_TIMER, 0, 0, 0, 0);
      // Software interrupts on ext bits 1 and 2
      add_step(OP_WRITE, reg_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_SWIRQ), 3, 0, 0);
      add_step(OP_CHECK_EXT, 0, 0, 32'h6, 0);
      add_step(OP_READ, reg_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_SWIRQ), 0, 3, 0);
      add_step(OP_WRITE, reg_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_SWIRQ), 1, 0, 0);
      add_step(OP_CHECK_EXT, 0, 0, 32'h2, 0);
      add_step(OP_WRITE, reg_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_SWIRQ), 0, 0, 0);
      add_step(OP_CHECK_EXT, 0, 0, 0, 0);
      // Unmapped selects 2 and 3
      add_step(OP_READ, reg_addr(2'd2, 4'd0), 0, 0, 1);
      add_step(OP_WRITE, reg_addr(2'd3, 4'd1), 32'hdead_beef, 0, 1);
      add_step(OP_READ, reg_addr(2'd3, 4'd5), 0, 0, 1);
      add_step(OP_READ, reg_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_DATA_OUT),
               0, 32'ha5c3_0f96, 0);
   endtask

   // ****************************************
   // Main sequence
   // ****************************************
   initial begin
      step_t       s;
      logic [31:0] pat;
      i_req   = 1'b0;
      i_we    = 1'b0;
      i_addr  = '0;
      i_wdata = '0;
      i_gpio  = '0;
      seed    = 32'h2499_aee3;
      pat     = $random(seed);
      build_steps(pat);
      wait_reset_release();
      for (int i = 0; i < steps_q.size(); i++) begin
         s = steps_q[i];
         @(negedge clk);
         case (s.op)
            OP_WRITE, OP_READ: run_access(s);
            OP_SET_GPIO:       i_gpio = s.wdata;
            OP_IDLE:           repeat (s.wdata) @(negedge clk);
            OP_CHECK_EXT:      check_value("o_ext_irq", 64'(o_ext_irq), 64'(s.exp_data[2:0]));
            OP_WAIT_TIMER:     wait_timer_irq(s.exp_data[0]);
            OP_CHECK_OUT:      check_value("o_gpio", 64'(o_gpio), 64'(s.exp_data));
            default:           check_value("o_gpio_oe", 64'(o_gpio_oe), 64'(s.exp_data));
         endcase
      end
      $display("TESTS PASSED");
      $finish;
   end

endmodule

// ==== build.f ====
soc_pkg.sv
wb_if.sv
wb_host_bridge.sv
wb_decoder.sv
gpio_regs.sv
sys_timer.sv
periph_top.sv
tb_clk_gen.sv
tb_periph_top.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator and run; the log decides pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_periph_top -f build.f -o sim_periph

./obj_dir/sim_periph > sim.log 2>&1 || true
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
   exit 0
fi
exit 1
